//--- readout_params.svh
// Channel count 2 to 8, FIFO depth a power of two and credits at most 15
`ifndef READOUT_PARAMS_SVH
`define READOUT_PARAMS_SVH

// Number of front-end source channels
`define READOUT_NUM_CH 4

// Width of a channel index inside the arbiter
`define READOUT_CH_IDX_W $clog2(`READOUT_NUM_CH)

// Words per channel FIFO
`define READOUT_FIFO_DEPTH 8

// Pointer width for one channel FIFO
`define READOUT_FIFO_AW $clog2(`READOUT_FIFO_DEPTH)

// Downstream buffer slots granted at reset
`define READOUT_CREDITS 6

`endif

//--- readout_pkg.sv
// Channel identifier holds 4 bits so at most 16 channels can be tagged
`default_nettype none

package readout_pkg;

    typedef logic [27:0] payload_t;    // One front-end source word
    typedef logic [3:0]  chan_id_t;    // Tag in the top of an output word
    typedef logic [31:0] word_t;       // Tag above payload
    typedef logic [3:0]  credit_t;     // Downstream buffer slots left
    typedef logic [7:0]  ovf_count_t;  // Saturating drop counter

    typedef logic [7:0]  bus_addr_t;
    typedef logic [7:0]  bus_byte_t;

    // Register map, overflow counter of channel c sits at REG_OVF_BASE + c
    typedef enum bus_addr_t {
        REG_ENABLE   = 8'h00,
        REG_CLEAR    = 8'h01,
        REG_CREDITS  = 8'h02,
        REG_OVF_BASE = 8'h04
    } reg_addr_e;

    // Builds the output word for one payload
    function automatic word_t tag_word(input chan_id_t id, input payload_t data);
        return {id, data};
    endfunction

endpackage

`default_nettype wire

//--- chan_if.sv
// One instance per channel and grant may only be raised while req is high
`default_nettype none

interface chan_if;
    import readout_pkg::*;

    logic  req;    // FIFO not empty
    logic  hold;   // Preempt request, only while not empty
    word_t word;   // Head of the FIFO, already tagged
    logic  grant;  // Pop strobe from the arbiter

    modport fifo (
        output req, hold, word,
        input  grant
    );

    modport arb (
        input  req, hold, word,
        output grant
    );
endinterface

`default_nettype wire

//--- channel_fifo.sv
// Writes to a full FIFO are dropped with an overflow pulse and writes while disabled vanish
`default_nettype none
`include "readout_params.svh"

module channel_fifo (
    input  logic                  bus_clk,
    input  logic                  rst_n,
    input  readout_pkg::chan_id_t chan_id,
    input  logic                  enable,
    input  logic                  wr_en,
    input  readout_pkg::payload_t wr_data,
    input  logic                  hold_in,
    output logic                  overflow,
    chan_if.fifo                  ch
);
    import readout_pkg::*;

    localparam int DEPTH = `READOUT_FIFO_DEPTH;
    localparam int AW    = `READOUT_FIFO_AW;

    word_t          mem [DEPTH];
    logic [AW-1:0]  wr_ptr;
    logic [AW-1:0]  rd_ptr;
    logic [AW:0]    count;  // One bit wider so a full buffer is representable
    logic           full;
    logic           empty;
    logic           push;
    logic           pop;

    assign full  = (count == (AW+1)'(DEPTH));
    assign empty = (count == '0);

    assign push     = wr_en && enable && !full;
    assign pop      = ch.grant;              // Arbiter grants only while req is high
    assign overflow = wr_en && enable && full;

    assign ch.req  = !empty;
    assign ch.hold = hold_in && !empty;      // Hold means nothing with no data
    assign ch.word = mem[rd_ptr];

    // Tagging happens on the way in
    always_ff @(posedge bus_clk) begin
        if (push) begin
            mem[wr_ptr] <= tag_word(chan_id, wr_data);
        end
    end

    always_ff @(posedge bus_clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;   // Wraps since depth is a power of two
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rr_arbiter.sv
// Sends at most one word per cycle and only while credits remain, output is one cycle behind grant
`default_nettype none
`include "readout_params.svh"

module rr_arbiter (
    input  logic                 bus_clk,
    input  logic                 rst_n,
    chan_if.arb                  chans [`READOUT_NUM_CH],
    input  logic                 credit_return,
    output readout_pkg::credit_t credits,
    output logic                 out_valid,
    output readout_pkg::word_t   out_data
);
    import readout_pkg::*;

    localparam int N  = `READOUT_NUM_CH;
    localparam int IW = `READOUT_CH_IDX_W;

    logic [N-1:0]  req_v;
    logic [N-1:0]  hold_v;
    logic [N-1:0]  grant_v;
    word_t         words [N];
    logic [IW-1:0] last;    // Channel granted most recently
    logic [IW-1:0] sel;
    logic          found;

    // Interface arrays need constant indices
    for (genvar i = 0; i < N; i++) begin : g_chan
        assign req_v[i]       = chans[i].req;
        assign hold_v[i]      = chans[i].hold;
        assign words[i]       = chans[i].word;
        assign chans[i].grant = grant_v[i];
    end

    // Hold keeps the last winner, otherwise search from the next channel
    always_comb begin
        int idx;
        found = 1'b0;
        sel   = last;
        idx   = 0;
        if (credits != '0) begin
            if (req_v[last] && hold_v[last]) begin
                found = 1'b1;
            end else begin
                for (int k = 1; k <= N; k++) begin
                    idx = (int'(last) + k) % N;
                    if (!found && req_v[idx]) begin
                        found = 1'b1;
                        sel   = IW'(idx);
                    end
                end
            end
        end
    end

    assign grant_v = found ? ({{(N-1){1'b0}}, 1'b1} << sel) : '0;

    always_ff @(posedge bus_clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            last      <= '0;
        end else begin
            out_valid <= found;
            if (found) begin
                last <= sel;
            end
        end
    end

    always_ff @(posedge bus_clk) begin
        if (found) begin
            out_data <= words[sel];
        end
    end

    // Send and return in one cycle cancel out
    always_ff @(posedge bus_clk) begin
        if (!rst_n) begin
            credits <= credit_t'(`READOUT_CREDITS);
        end else begin
            case ({found, credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- readout_regs.sv
// Read data appears one cycle after bus_rd and unmapped addresses read as zero
`default_nettype none
`include "readout_params.svh"

module readout_regs (
    input  logic                           bus_clk,
    input  logic                           rst_n,
    input  readout_pkg::bus_addr_t         bus_add,
    input  readout_pkg::bus_byte_t         bus_wr_data,
    input  logic                           bus_wr,
    input  logic                           bus_rd,
    output readout_pkg::bus_byte_t         bus_rd_data,
    input  logic [`READOUT_NUM_CH-1:0]     overflow,
    input  readout_pkg::credit_t           credits,
    output logic [`READOUT_NUM_CH-1:0]     chan_enable
);
    import readout_pkg::*;

    localparam int N = `READOUT_NUM_CH;

    ovf_count_t ovf_cnt [N];
    bus_byte_t  rd_mux;
    logic       clr;

    assign clr = bus_wr && (bus_add == REG_CLEAR);   // Data value is ignored

    always_ff @(posedge bus_clk) begin
        if (!rst_n) begin
            chan_enable <= '1;                         // All channels on
        end else if (bus_wr && (bus_add == REG_ENABLE)) begin
            chan_enable <= bus_wr_data[N-1:0];
        end
    end

    // Counters stick at the top value
    always_ff @(posedge bus_clk) begin
        if (!rst_n) begin
            for (int c = 0; c < N; c++) begin
                ovf_cnt[c] <= '0;
            end
        end else begin
            for (int c = 0; c < N; c++) begin
                if (clr) begin
                    ovf_cnt[c] <= '0;
                end else if (overflow[c] && (ovf_cnt[c] != '1)) begin
                    ovf_cnt[c] <= ovf_cnt[c] + 1'b1;
                end
            end
        end
    end

    always_comb begin
        rd_mux = '0;
        case (bus_add)
            REG_ENABLE:  rd_mux = bus_byte_t'(chan_enable);
            REG_CREDITS: rd_mux = bus_byte_t'(credits);
            default: begin
                for (int c = 0; c < N; c++) begin
                    if (bus_add == bus_addr_t'(REG_OVF_BASE + c)) begin
                        rd_mux = ovf_cnt[c];
                    end
                end
            end
        endcase
    end

    always_ff @(posedge bus_clk) begin
        if (!rst_n) begin
            bus_rd_data <= '0;
        end else if (bus_rd) begin
            bus_rd_data <= rd_mux;   // Holds until the next read
        end
    end

endmodule

`default_nettype wire

//--- readout_top.sv
// Single clock design and credit_return must never exceed the words already sent
`default_nettype none
`include "readout_params.svh"

module readout_top (
    input  logic                                          bus_clk,
    input  logic                                          rst_n,
    input  logic [`READOUT_NUM_CH-1:0]                    wr_en,
    input  readout_pkg::payload_t [`READOUT_NUM_CH-1:0]   wr_data,
    input  logic [`READOUT_NUM_CH-1:0]                    hold,
    input  logic                                          credit_return,
    output logic                                          out_valid,
    output readout_pkg::word_t                            out_data,
    input  readout_pkg::bus_addr_t                        bus_add,
    input  readout_pkg::bus_byte_t                        bus_wr_data,
    input  logic                                          bus_wr,
    input  logic                                          bus_rd,
    output readout_pkg::bus_byte_t                        bus_rd_data
);
    import readout_pkg::*;

    localparam int N = `READOUT_NUM_CH;

    logic [N-1:0] chan_enable;
    logic [N-1:0] overflow;
    credit_t      credits;

    chan_if ch_if [N] ();

    // Instance index doubles as the channel tag
    for (genvar i = 0; i < N; i++) begin : g_fifo
        channel_fifo fifo_i (
            .bus_clk  (bus_clk),
            .rst_n    (rst_n),
            .chan_id  (chan_id_t'(i)),
            .enable   (chan_enable[i]),
            .wr_en    (wr_en[i]),
            .wr_data  (wr_data[i]),
            .hold_in  (hold[i]),
            .overflow (overflow[i]),
            .ch       (ch_if[i])
        );
    end

    rr_arbiter arb_i (
        .bus_clk       (bus_clk),
        .rst_n         (rst_n),
        .chans         (ch_if),
        .credit_return (credit_return),
        .credits       (credits),
        .out_valid     (out_valid),
        .out_data      (out_data)
    );

    readout_regs regs_i (
        .bus_clk     (bus_clk),
        .rst_n       (rst_n),
        .bus_add     (bus_add),
        .bus_wr_data (bus_wr_data),
        .bus_wr      (bus_wr),
        .bus_rd      (bus_rd),
        .bus_rd_data (bus_rd_data),
        .overflow    (overflow),
        .credits     (credits),
        .chan_enable (chan_enable)
    );

endmodule

`default_nettype wire

//--- readout_properties.sv
// Bound to rr_arbiter, assumes one clock and the synchronous active low reset
`default_nettype none
`include "readout_params.svh"

module readout_properties (
    input logic                 bus_clk,
    input logic                 rst_n,
    input readout_pkg::credit_t credits,
    input logic                 out_valid
);
    import readout_pkg::*;

    // A word on the output needs a credit in its grant cycle
    property p_send_needs_credit;
        @(posedge bus_clk) disable iff (!rst_n)
            out_valid |-> ($past(credits) != '0);
    endproperty

    property p_credit_bound;
        @(posedge bus_clk) disable iff (!rst_n)
            (credits <= credit_t'(`READOUT_CREDITS));
    endproperty

    property p_quiet_in_reset;
        @(posedge bus_clk) !rst_n |=> !out_valid;   // Reset is sampled at the edge
    endproperty

    a_send_needs_credit: assert property (p_send_needs_credit)
        else $error("out_valid raised while no credit was left");

    a_credit_bound: assert property (p_credit_bound)
        else $error("credit count above the downstream buffer size");

    a_quiet_in_reset: assert property (p_quiet_in_reset)
        else $error("out_valid high during reset");

endmodule

`default_nettype wire

//--- readout_tb.sv
// Needs 2 to 8 channels and the fixed LFSR seed gives the same stimulus on every run
`default_nettype none
`include "readout_params.svh"

module readout_tb;
    import readout_pkg::*;

    localparam int N            = `READOUT_NUM_CH;
    localparam int DEPTH        = `READOUT_FIFO_DEPTH;
    localparam int CREDITS      = `READOUT_CREDITS;
    localparam int RESET_CYCLES = 10;
    localparam int RAND_CYCLES  = 600;
    localparam int DIRECTED     = 400;   // Register checks, stalls and directed bursts
    localparam int DRAIN_MARGIN = 300;
    localparam int MAX_CYCLES   = RESET_CYCLES + RAND_CYCLES + DIRECTED + DRAIN_MARGIN;
    localparam int OVF_CH       = 1;
    localparam int OVF_EXTRA    = 3;
    localparam int HOLD_CH      = 1;
    localparam int DIS_CH       = N - 1;

    logic                 bus_clk;
    logic                 rst_n;
    logic [N-1:0]         wr_en;
    payload_t [N-1:0]     wr_data;
    logic [N-1:0]         hold;
    logic                 credit_return;
    logic                 out_valid;
    word_t                out_data;
    bus_addr_t            bus_add;
    bus_byte_t            bus_wr_data;
    logic                 bus_wr;
    logic                 bus_rd;
    bus_byte_t            bus_rd_data;

    payload_t     exp_q [N][$];   // Accepted words not yet seen on the output
    logic [N-1:0] en_model   = '1;
    int           ovf_model [N];
    int           sent_cnt   = 0;
    int           ret_seen   = 0;
    int           ret_issued = 0;
    int           cyc        = 0;
    logic         hold_check = 1'b0;
    logic [15:0]  lfsr_state = 16'd16;

    readout_top dut_i (.*);

    bind rr_arbiter readout_properties props_i (
        .bus_clk   (bus_clk),
        .rst_n     (rst_n),
        .credits   (credits),
        .out_valid (out_valid)
    );

    always #4 bus_clk = ~bus_clk;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = {1'b0, lfsr_state[15:1]} ^ (lfsr_state[0] ? 16'hB400 : 16'h0000);
        end
        return v;
    endfunction

    function automatic logic [N-1:0] chan_bit(input int c);
        logic [N-1:0] m;
        m = '0;
        m[c] = 1'b1;
        return m;
    endfunction

    function automatic logic queues_empty();
        for (int c = 0; c < N; c++) begin
            if (exp_q[c].size() != 0) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    // Drives one clock of stimulus and returns a credit only for a word already seen
    task automatic drive_cycle(input logic [N-1:0] we, input logic [N-1:0] hd, input logic ret_ok);
        logic [31:0] r;
        @(posedge bus_clk);
        for (int c = 0; c < N; c++) begin
            r = rand_bits(28);
            wr_data[c] <= r[27:0];
        end
        wr_en <= we;
        hold  <= hd;
        if (ret_ok && (sent_cnt > ret_issued)) begin
            credit_return <= 1'b1;
            ret_issued++;
        end else begin
            credit_return <= 1'b0;
        end
    endtask

    task automatic random_traffic(input int cycles);
        logic [N-1:0] we;
        logic [N-1:0] hd;
        logic [31:0]  r;
        for (int i = 0; i < cycles; i++) begin
            for (int c = 0; c < N; c++) begin
                r = rand_bits(2);
                we[c] = (r[1:0] == 2'b00) && (exp_q[c].size() < DEPTH - 2);  // Stay clear of full
                r = rand_bits(3);
                hd[c] = (r[2:0] == 3'b000);
            end
            r = rand_bits(1);
            drive_cycle(we, hd, r[0]);
        end
    endtask

    task automatic drain_all(input logic [N-1:0] hd);
        int quiet;
        quiet = 0;
        while (quiet < 3) begin
            drive_cycle('0, hd, 1'b1);
            if (queues_empty() && (sent_cnt == ret_issued)) begin
                quiet++;
            end else begin
                quiet = 0;
            end
        end
    endtask

    // Spend every credit on channel 0 so the arbiter sits at zero credits
    task automatic stall_arbiter();
        repeat (CREDITS) drive_cycle(chan_bit(0), '0, 1'b0);
        while (!((exp_q[0].size() == 0) && ((sent_cnt - ret_seen) == CREDITS))) begin
            drive_cycle('0, '0, 1'b0);
        end
        repeat (2) drive_cycle('0, '0, 1'b0);
    endtask

    task automatic bus_write(input bus_addr_t addr, input bus_byte_t data);
        @(posedge bus_clk);
        bus_add       <= addr;
        bus_wr_data   <= data;
        bus_wr        <= 1'b1;
        wr_en         <= '0;
        credit_return <= 1'b0;
        @(posedge bus_clk);
        bus_wr <= 1'b0;
    endtask

    task automatic check_reg(input bus_addr_t addr, input int exp, input string name);
        bus_byte_t got;
        @(posedge bus_clk);
        bus_add       <= addr;
        bus_rd        <= 1'b1;
        wr_en         <= '0;
        credit_return <= 1'b0;
        @(posedge bus_clk);
        bus_rd <= 1'b0;
        @(posedge bus_clk);
        got = bus_rd_data;   // Registered one cycle after the read strobe
        assert (got == bus_byte_t'(exp)) else report_failure($sformatf(
            "MISMATCH t=%0t %s got=%0h exp=%0h", $time, name, got, exp[7:0]));
    endtask

    task automatic check_all_ovf();
        for (int c = 0; c < N; c++) begin
            check_reg(bus_addr_t'(REG_OVF_BASE + c), ovf_model[c], $sformatf("REG_OVF_%0d", c));
        end
    endtask

    task automatic check_credits();
        check_reg(REG_CREDITS, CREDITS - (sent_cnt - ret_seen), "REG_CREDITS");
    endtask

    // Reference model samples mid-cycle what the DUT takes at the next rising edge
    always @(negedge bus_clk) begin : model
        int       id;
        payload_t exp_pay;
        if (rst_n) begin
            if (out_valid) begin
                id = int'(out_data[31:28]);
                assert (id < N) else report_failure("Output word carries an unknown channel tag");
                assert (exp_q[id].size() > 0) else report_failure(
                    $sformatf("Output word from channel %0d which has nothing pending", id));
                if (hold_check && (exp_q[HOLD_CH].size() > 0)) begin
                    assert (id == HOLD_CH) else report_failure($sformatf(
                        "MISMATCH t=%0t out_data channel got=%0d exp=%0d", $time, id, HOLD_CH));
                end
                exp_pay = exp_q[id].pop_front();
                assert (out_data[27:0] == exp_pay) else report_failure($sformatf(
                    "MISMATCH t=%0t out_data payload got=%h exp=%h", $time, out_data[27:0],
                    exp_pay));
                sent_cnt++;
            end
            if (credit_return) begin
                ret_seen++;
            end
            assert ((sent_cnt - ret_seen) <= CREDITS) else
                report_failure("More words in flight than the downstream buffer holds");
            for (int c = 0; c < N; c++) begin
                if (wr_en[c] && en_model[c]) begin
                    if (exp_q[c].size() == DEPTH) begin
                        if (ovf_model[c] < 255) ovf_model[c]++;
                    end else begin
                        exp_q[c].push_back(wr_data[c]);
                    end
                end
            end
            if (bus_wr && (bus_add == REG_ENABLE)) begin
                en_model = bus_wr_data[N-1:0];
            end else if (bus_wr && (bus_add == REG_CLEAR)) begin
                for (int c = 0; c < N; c++) ovf_model[c] = 0;
            end
        end
    end

    always @(posedge bus_clk) begin
        cyc <= cyc + 1;
        assert (cyc < MAX_CYCLES) else report_failure("Timeout, the run exceeded its cycle limit");
    end

    initial begin
        bus_clk       = 1'b0;
        rst_n         = 1'b0;
        wr_en         = '0;
        wr_data       = '0;
        hold          = '0;
        credit_return = 1'b0;
        bus_add       = '0;
        bus_wr_data   = '0;
        bus_wr        = 1'b0;
        bus_rd        = 1'b0;
        repeat (RESET_CYCLES) @(posedge bus_clk);
        rst_n <= 1'b1;

        repeat (5) begin
            @(posedge bus_clk);
            assert (out_valid == 1'b0) else report_failure($sformatf(
                "MISMATCH t=%0t out_valid got=%b exp=0", $time, out_valid));
        end
        check_reg(REG_ENABLE, (1 << N) - 1, "REG_ENABLE");
        check_reg(REG_CREDITS, CREDITS, "REG_CREDITS");
        check_reg(8'h03, 0, "unused address 3");
        check_all_ovf();

        random_traffic(RAND_CYCLES);
        drain_all('0);
        check_credits();
        check_all_ovf();

        // Overflow on one channel while the arbiter is stalled
        stall_arbiter();
        check_credits();
        repeat (DEPTH + OVF_EXTRA) drive_cycle(chan_bit(OVF_CH), '0, 1'b0);
        check_reg(bus_addr_t'(REG_OVF_BASE + OVF_CH), OVF_EXTRA, "REG_OVF after burst");
        bus_write(REG_CLEAR, 8'h00);
        check_reg(bus_addr_t'(REG_OVF_BASE + OVF_CH), 0, "REG_OVF after clear");
        drain_all('0);

        // Buffered words drain after disable and later ones vanish
        stall_arbiter();
        repeat (4) drive_cycle(chan_bit(DIS_CH), '0, 1'b0);
        bus_write(REG_ENABLE, bus_byte_t'(~chan_bit(DIS_CH)));
        repeat (DEPTH + 2) drive_cycle(chan_bit(DIS_CH), '0, 1'b0);
        check_reg(REG_ENABLE, int'(en_model), "REG_ENABLE");
        drain_all('0);
        check_all_ovf();
        bus_write(REG_ENABLE, 8'hFF);

        stall_arbiter();
        repeat (5) drive_cycle(chan_bit(0) | chan_bit(HOLD_CH), '0, 1'b0);
        hold_check = 1'b1;   // First grant goes to HOLD_CH since channel 0 won last
        drain_all(chan_bit(HOLD_CH));
        hold_check = 1'b0;
        check_credits();

        drive_cycle('0, '0, 1'b0);
        if (queues_empty() && (sent_cnt == ret_seen)) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            report_failure("Words or credits still outstanding at the end of the run");
        end
    end

endmodule

`default_nettype wire

//--- project.f
+incdir+.
readout_pkg.sv
chan_if.sv
channel_fifo.sv
rr_arbiter.sv
readout_regs.sv
readout_top.sv
readout_properties.sv
readout_tb.sv

//--- Makefile
# Verilator simulation of the readout merger

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, fails on a failed check"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module readout_tb \
		-f project.f -o readout_sim
	./obj_dir/readout_sim

clean:
	rm -rf obj_dir
